// File: include/dcache_defs.svh
// ~~~~~~~~~~~~~~~~~~~~
// Data cache geometry and widths
// Include wherever sizes of the cache arrays or ports are needed
// ~~~~~~~~~~~~~~~~~~~~
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

`define DC_ADDR_W   32   // CPU and memory address width
`define DC_WAYS     2    // Fixed, LRU is a single bit per set
`define DC_SETS     32
`define DC_INDEX_W  5
`define DC_WORDS    4    // Words per line

`define DC_WOFS_W   2
`define DC_TAG_W    23   // Address minus index and line offset
`define DC_CNT_W    16   // Hit and miss counters

`endif

// File: verilog/dcache_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Shared types of the data cache
// Imported by the lookup, store, sequencer and top
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "dcache_defs.svh"

package dcache_pkg;

    // CPU address, flat or split into cache fields
    typedef union packed {
        logic [`DC_ADDR_W-1:0] word;
        struct packed {
            logic [`DC_TAG_W-1:0]   tag;
            logic [`DC_INDEX_W-1:0] index;
            logic [`DC_WOFS_W-1:0]  wofs;   // Word within line
            logic [1:0]             bofs;   // Byte within word
        } f;
    } dc_addr_u;

    typedef enum logic [1:0] {
        DC_BYTE = 2'b00,
        DC_HALF = 2'b01,
        DC_WORD = 2'b10
    } dc_size_e;

    // Controller states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WBACK,    // Dirty victim to memory
        ST_FILL,     // Line from memory
        ST_DONE
    } dc_state_e;

endpackage

`default_nettype wire

// File: verilog/dcache_tag_lookup.sv
// ~~~~~~~~~~~~~~~~~~~~
// Tag, valid, dirty and LRU state of the data cache
// Flags a hit for the current address and names the way to evict
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_tag_lookup
    import dcache_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,
    input  wire dc_addr_u    cpu_addr,
    input  wire dc_state_e   state,
    input  wire              cpu_write,
    input  wire              fill_done,    // Last fill beat accepted
    input  wire              fill_way,
    input  wire              flush,
    output logic             hit,
    output logic             hit_way,
    output logic             victim_way,
    output logic             victim_dirty,
    output logic [`DC_TAG_W-1:0] victim_tag
);

    logic [`DC_TAG_W-1:0]   tag_mem [`DC_SETS][`DC_WAYS];
    logic [`DC_WAYS-1:0]    valid_q [`DC_SETS];
    logic [`DC_WAYS-1:0]    dirty_q [`DC_SETS];
    logic [`DC_SETS-1:0]    lru_q;         // Way to replace next, per set
    logic [`DC_INDEX_W-1:0] idx;
    logic [`DC_WAYS-1:0]    way_hit;

    assign idx = cpu_addr.f.index;

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            way_hit[w] = valid_q[idx][w] && (tag_mem[idx][w] == cpu_addr.f.tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];   // Ways never hold the same tag

    // Empty ways are used before the LRU choice
    always_comb begin
        if (!valid_q[idx][0]) begin
            victim_way = 1'b0;
        end else if (!valid_q[idx][1]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru_q[idx];
        end
    end

    assign victim_dirty = valid_q[idx][victim_way] && dirty_q[idx][victim_way];
    assign victim_tag   = tag_mem[idx][victim_way];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
            lru_q <= '0;
        end else if (flush) begin
            // Dirty lines are dropped, nothing goes to memory
            for (int s = 0; s < `DC_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
            lru_q <= '0;
        end else begin
            if (state == ST_LOOKUP && hit) begin
                lru_q[idx] <= ~hit_way;                       // Point at the other way
                if (cpu_write) begin
                    dirty_q[idx][hit_way] <= 1'b1;
                end
            end
            if (fill_done) begin
                valid_q[idx][fill_way] <= 1'b1;
                dirty_q[idx][fill_way] <= 1'b0;
            end
        end
    end

    // New tag goes in with the last fill beat
    always_ff @(posedge clk) begin
        if (fill_done) begin
            tag_mem[idx][fill_way] <= cpu_addr.f.tag;
        end
    end

endmodule

`default_nettype wire

// File: verilog/dcache_line_store.sv
// ~~~~~~~~~~~~~~~~~~~~
// Line data array of the data cache
// Merges CPU writes by size and byte enable, takes fill beats whole
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_line_store
    import dcache_pkg::*;
(
    input  wire                  clk,
    input  wire dc_addr_u        cpu_addr,
    input  wire dc_size_e        cpu_size,
    input  wire [31:0]           cpu_wdata,
    input  wire [3:0]            cpu_be,
    input  wire                  wr_en,      // CPU write hit
    input  wire                  way,
    input  wire                  fill_en,    // Fill beat accepted
    input  wire [`DC_WOFS_W-1:0] beat,
    input  wire                  beat_sel,   // Index by beat, not address
    input  wire [31:0]           mem_rdata,
    output logic [31:0]          rd_word,
    output logic [31:0]          cpu_rdata
);

    logic [31:0]            data_mem [`DC_SETS][`DC_WAYS][`DC_WORDS];
    logic [`DC_INDEX_W-1:0] idx;
    logic [`DC_WOFS_W-1:0]  wsel;
    logic [1:0]             bofs;
    logic [31:0]            merged;

    assign idx  = cpu_addr.f.index;
    assign bofs = cpu_addr.f.bofs;
    assign wsel = beat_sel ? beat : cpu_addr.f.wofs;

    assign rd_word = data_mem[idx][way][wsel];

    // Store data over the old word
    always_comb begin
        merged = rd_word;
        case (cpu_size)
            DC_BYTE: begin
                if (cpu_be[0]) begin
                    merged[8*bofs +: 8] = cpu_wdata[7:0];
                end
            end
            DC_HALF: begin
                // Low data half goes to the lane picked by address bit 1
                if (|cpu_be[1:0]) begin
                    merged[16*bofs[1] +: 16] = cpu_wdata[15:0];
                end
            end
            default: begin
                for (int b = 0; b < 4; b++) begin
                    if (cpu_be[b]) begin
                        merged[8*b +: 8] = cpu_wdata[8*b +: 8];
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            data_mem[idx][way][wsel] <= mem_rdata;
        end else if (wr_en) begin
            data_mem[idx][way][wsel] <= merged;
        end
    end

    // Narrow reads come back zero-extended
    always_comb begin
        case (cpu_size)
            DC_BYTE: cpu_rdata = {24'h0, rd_word[8*bofs +: 8]};
            DC_HALF: cpu_rdata = {16'h0, rd_word[16*bofs[1] +: 16]};
            default: cpu_rdata = rd_word;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/dcache_miss_seq.sv
// ~~~~~~~~~~~~~~~~~~~~
// Data cache controller
// Runs lookup, write-back and fill, drives memory beats and counters
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_miss_seq
    import dcache_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   cpu_req,
    input  wire dc_addr_u         cpu_addr,
    input  wire                   cpu_write,
    input  wire                   hit,
    input  wire                   hit_way,
    input  wire                   victim_way,
    input  wire                   victim_dirty,
    input  wire [`DC_TAG_W-1:0]   victim_tag,
    input  wire [31:0]            rd_word,
    input  wire                   mem_ready,
    input  wire                   cache_flush,
    output dc_state_e             state,
    output logic                  way,
    output logic [`DC_WOFS_W-1:0] beat,
    output logic                  beat_sel,
    output logic                  wr_en,
    output logic                  fill_en,
    output logic                  fill_done,
    output logic                  cpu_ready,
    output logic                  cpu_hit,
    output logic                  mem_req,
    output logic                  mem_write,
    output logic [`DC_ADDR_W-1:0] mem_addr,
    output logic [31:0]           mem_wdata,
    output logic [`DC_CNT_W-1:0]  hit_count,
    output logic [`DC_CNT_W-1:0]  miss_count
);

    dc_state_e            next_state;
    logic                 miss_way_q;
    logic [`DC_TAG_W-1:0] miss_tag_q;   // Tag of the line being written back
    logic                 first_q;      // Lookup not yet counted
    logic                 last_beat;
    dc_addr_u             beat_addr;

    assign last_beat = (beat == `DC_WOFS_W'(`DC_WORDS-1));

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE:   if (cpu_req) next_state = ST_LOOKUP;
            ST_LOOKUP: begin
                if (hit) begin
                    next_state = ST_DONE;
                end else if (victim_dirty) begin
                    next_state = ST_WBACK;
                end else begin
                    next_state = ST_FILL;
                end
            end
            ST_WBACK:  if (mem_ready && last_beat) next_state = ST_FILL;
            ST_FILL:   if (mem_ready && last_beat) next_state = ST_LOOKUP;  // Retry hits
            default:   next_state = ST_IDLE;
        endcase
        if (cache_flush) begin
            next_state = ST_IDLE;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            beat       <= '0;
            first_q    <= 1'b0;
            cpu_hit    <= 1'b0;
            hit_count  <= '0;
            miss_count <= '0;
        end else begin
            state <= next_state;
            if (cache_flush) begin
                beat <= '0;
            end else if (mem_req && mem_ready) begin
                beat <= beat + 1'b1;      // Wraps to zero after the last beat
            end
            if (state == ST_IDLE) begin
                first_q <= cpu_req;
            end else if (state == ST_LOOKUP) begin
                first_q <= 1'b0;
            end
            // Only the first lookup of a request is counted
            if (state == ST_LOOKUP && first_q) begin
                cpu_hit <= hit;
                if (hit) begin
                    hit_count <= hit_count + 1'b1;
                end else begin
                    miss_count <= miss_count + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_LOOKUP && !hit) begin
            miss_way_q <= victim_way;
            miss_tag_q <= victim_tag;
        end
    end

    // Memory phases use the latched victim, lookup uses the hit way
    assign beat_sel  = (state == ST_WBACK) || (state == ST_FILL);
    assign way       = beat_sel ? miss_way_q : hit_way;

    assign wr_en     = (state == ST_LOOKUP) && hit && cpu_write;
    assign fill_en   = (state == ST_FILL) && mem_ready;
    assign fill_done = fill_en && last_beat;
    assign cpu_ready = (state == ST_DONE);

    assign mem_req   = beat_sel;
    assign mem_write = (state == ST_WBACK);

    always_comb begin
        beat_addr.f.tag   = mem_write ? miss_tag_q : cpu_addr.f.tag;
        beat_addr.f.index = cpu_addr.f.index;
        beat_addr.f.wofs  = beat;
        beat_addr.f.bofs  = 2'b00;
    end

    assign mem_addr  = beat_addr.word;
    assign mem_wdata = mem_write ? rd_word : 32'h0;

endmodule

`default_nettype wire

// File: verilog/dcache_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// Data cache top level
// 2-way write-back cache between a CPU port and a memory port
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   cpu_req,
    input  wire dc_addr_u         cpu_addr,
    input  wire                   cpu_write,
    input  wire dc_size_e         cpu_size,
    input  wire [31:0]            cpu_wdata,
    input  wire [3:0]             cpu_be,
    output logic [31:0]           cpu_rdata,
    output logic                  cpu_hit,
    output logic                  cpu_ready,
    output logic                  mem_req,
    output logic                  mem_write,
    output logic [`DC_ADDR_W-1:0] mem_addr,
    output logic [31:0]           mem_wdata,
    input  wire [31:0]            mem_rdata,
    input  wire                   mem_ready,
    input  wire                   cache_flush,
    output logic [`DC_CNT_W-1:0]  hit_count,
    output logic [`DC_CNT_W-1:0]  miss_count
);

    dc_state_e             state;
    logic                  hit;
    logic                  hit_way;
    logic                  victim_way;
    logic                  victim_dirty;
    logic [`DC_TAG_W-1:0]  victim_tag;
    logic                  way;
    logic [`DC_WOFS_W-1:0] beat;
    logic                  beat_sel;
    logic                  wr_en;
    logic                  fill_en;
    logic                  fill_done;
    logic [31:0]           rd_word;

    dcache_tag_lookup u_tag_lookup (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_addr     (cpu_addr),
        .state        (state),
        .cpu_write    (cpu_write),
        .fill_done    (fill_done),
        .fill_way     (way),
        .flush        (cache_flush),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    dcache_line_store u_line_store (
        .clk       (clk),
        .cpu_addr  (cpu_addr),
        .cpu_size  (cpu_size),
        .cpu_wdata (cpu_wdata),
        .cpu_be    (cpu_be),
        .wr_en     (wr_en),
        .way       (way),
        .fill_en   (fill_en),
        .beat      (beat),
        .beat_sel  (beat_sel),
        .mem_rdata (mem_rdata),
        .rd_word   (rd_word),
        .cpu_rdata (cpu_rdata)
    );

    dcache_miss_seq u_miss_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_req      (cpu_req),
        .cpu_addr     (cpu_addr),
        .cpu_write    (cpu_write),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .rd_word      (rd_word),
        .mem_ready    (mem_ready),
        .cache_flush  (cache_flush),
        .state        (state),
        .way          (way),
        .beat         (beat),
        .beat_sel     (beat_sel),
        .wr_en        (wr_en),
        .fill_en      (fill_en),
        .fill_done    (fill_done),
        .cpu_ready    (cpu_ready),
        .cpu_hit      (cpu_hit),
        .mem_req      (mem_req),
        .mem_write    (mem_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .hit_count    (hit_count),
        .miss_count   (miss_count)
    );

endmodule

`default_nettype wire

// File: bench/dcache_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// Testbench for the data cache, replays the access patterns file
// against a sparse memory model with random ready stalls
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_tb
    import dcache_pkg::*;
();

    localparam int          PAT_MAX      = 64;
    localparam int          TIMEOUT      = 200;    // Cycles per wait
    localparam int          WB_BEATS_EXP = 4;      // One dirty eviction in the patterns
    localparam logic [31:0] OP_READ      = 32'h0;
    localparam logic [31:0] OP_WRITE     = 32'h1;
    localparam logic [31:0] OP_FLUSH     = 32'h2;
    localparam logic [31:0] OP_END       = 32'hf;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  cpu_req;
    logic [`DC_ADDR_W-1:0] cpu_addr;
    logic                  cpu_write;
    dc_size_e              cpu_size;
    logic [31:0]           cpu_wdata;
    logic [3:0]            cpu_be;
    logic [31:0]           cpu_rdata;
    logic                  cpu_hit;
    logic                  cpu_ready;
    logic                  mem_req;
    logic                  mem_write;
    logic [`DC_ADDR_W-1:0] mem_addr;
    logic [31:0]           mem_wdata;
    logic [31:0]           mem_rdata = 32'h0;
    logic                  mem_ready = 1'b0;
    logic                  cache_flush;
    logic [`DC_CNT_W-1:0]  hit_count;
    logic [`DC_CNT_W-1:0]  miss_count;

    logic [31:0] pat_mem [0:7*PAT_MAX-1];    // Seven words per pattern
    logic [31:0] mem_words [logic [31:0]];   // Written words only
    logic [31:0] lfsr = 32'he2f8_61e3;
    int          wb_beats = 0;

    dcache_top u_dcache_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .cpu_req     (cpu_req),
        .cpu_addr    (cpu_addr),
        .cpu_write   (cpu_write),
        .cpu_size    (cpu_size),
        .cpu_wdata   (cpu_wdata),
        .cpu_be      (cpu_be),
        .cpu_rdata   (cpu_rdata),
        .cpu_hit     (cpu_hit),
        .cpu_ready   (cpu_ready),
        .mem_req     (mem_req),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata),
        .mem_ready   (mem_ready),
        .cache_flush (cache_flush),
        .hit_count   (hit_count),
        .miss_count  (miss_count)
    );

    always #5 clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] mem_read(input logic [31:0] addr);
        logic [31:0] word_addr;
        word_addr = {addr[31:2], 2'b00};
        if (mem_words.exists(word_addr)) begin
            mem_read = mem_words[word_addr];
        end else begin
            mem_read = word_addr ^ 32'h5a5a_0000;   // Unwritten word
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "run stopped");
    endtask

    // Memory model, one LFSR step per cycle decides the ready
    always @(negedge clk) begin
        if (!rst_n) begin
            mem_ready = 1'b0;
        end else begin
            lfsr = lfsr_step(lfsr);
            if (lfsr[0] && mem_req && mem_write) begin
                // Beat completes at the next rising edge
                check_value("mem_addr word offset", 32'(mem_addr[3:2]), 32'(wb_beats % 4));
                mem_words[{mem_addr[31:2], 2'b00}] = mem_wdata;
                wb_beats++;
            end
            mem_rdata = mem_read(mem_addr);
            mem_ready = lfsr[0];
        end
    end

    task wait_ready(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_run("timeout, cpu_ready never came for the request");
            end
        end while (!cpu_ready);
    endtask

    task run_access(input int base);
        int cycles;
        @(negedge clk);                               // Idle cycle between requests
        check_value("cpu_ready", 32'(cpu_ready), 32'd0);
        cpu_req   = 1'b1;
        cpu_addr  = pat_mem[base+1];
        cpu_write = (pat_mem[base] == OP_WRITE);
        cpu_size  = dc_size_e'(pat_mem[base+2][1:0]);
        cpu_wdata = pat_mem[base+3];
        cpu_be    = pat_mem[base+4][3:0];
        wait_ready(cycles);
        check_value("cpu_hit", 32'(cpu_hit), pat_mem[base+6]);
        if (!cpu_write) begin
            check_value("cpu_rdata", cpu_rdata, pat_mem[base+5]);
        end
        if (pat_mem[base+6][0]) begin
            check_value("cpu_ready latency", 32'(cycles), 32'd2);
        end
        cpu_req = 1'b0;
    endtask

    task apply_flush();
        @(negedge clk);
        cache_flush = 1'b1;
        @(negedge clk);
        cache_flush = 1'b0;
    endtask

    initial begin
        int          p;
        int          base;
        int          exp_hits;
        int          exp_misses;
        logic [31:0] op;
        logic        found_end;
        rst_n       = 1'b0;
        cpu_req     = 1'b0;
        cpu_addr    = '0;
        cpu_write   = 1'b0;
        cpu_size    = DC_WORD;
        cpu_wdata   = '0;
        cpu_be      = '0;
        cache_flush = 1'b0;
        exp_hits    = 0;
        exp_misses  = 0;
        found_end   = 1'b0;
        $readmemh("bench/dcache_patterns.txt", pat_mem);
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        check_value("mem_req", 32'(mem_req), 32'd0);
        check_value("cpu_ready", 32'(cpu_ready), 32'd0);
        check_value("hit_count", 32'(hit_count), 32'd0);
        check_value("miss_count", 32'(miss_count), 32'd0);

        p = 0;
        while (!found_end && p < PAT_MAX) begin
            base = 7 * p;
            op   = pat_mem[base];
            if (op == OP_END) begin
                found_end = 1'b1;
            end else if (op == OP_FLUSH) begin
                apply_flush();
            end else if (op == OP_READ || op == OP_WRITE) begin
                run_access(base);
                if (pat_mem[base+6][0]) begin
                    exp_hits++;
                end else begin
                    exp_misses++;
                end
            end else begin
                stop_run($sformatf("unknown operation %h in pattern %0d", op, p));
            end
            p++;
        end
        if (!found_end) begin
            stop_run("pattern file has no end marker");
        end

        check_value("hit_count", 32'(hit_count), 32'(exp_hits));
        check_value("miss_count", 32'(miss_count), 32'(exp_misses));
        check_value("write-back beats", 32'(wb_beats), 32'(WB_BEATS_EXP));
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/dcache_patterns.txt
// op (0 read, 1 write, 2 flush, f end)  addr  size (0 byte, 1 half, 2 word)
// wdata  be  exp_rdata (reads only)  exp_hit
0 00001010 2 00000000 f 5a5a1010 0
0 00001014 2 00000000 f 5a5a1014 1
1 00001011 0 000000ab 1 00000000 1
1 00001012 1 0000beef 3 00000000 1
0 00001010 0 00000000 f 00000010 1
0 00001011 0 00000000 f 000000ab 1
0 00001012 1 00000000 f 0000beef 1
0 00001010 2 00000000 f beefab10 1
1 00001018 2 11223344 5 00000000 1
0 00001018 2 00000000 f 5a221044 1
// Three tags in set 1
0 00001210 2 00000000 f 5a5a1210 0
0 00001014 2 00000000 f 5a5a1014 1
0 00001410 2 00000000 f 5a5a1410 0
0 00001214 2 00000000 f 5a5a1214 0
0 0000141c 2 00000000 f 5a5a141c 1
0 00001010 2 00000000 f beefab10 0
0 00001018 2 00000000 f 5a221044 1
0 00001013 0 00000000 f 000000be 1
// Dirty data dropped by the flush
1 00001018 2 cafef00d f 00000000 1
0 00001018 2 00000000 f cafef00d 1
2 00000000 0 00000000 0 00000000 0
0 00001018 2 00000000 f 5a221044 0
// Write miss allocates
1 00002020 1 00001234 3 00000000 0
0 00002020 2 00000000 f 5a5a1234 1
0 00002022 1 00000000 f 00005a5a 1
f 00000000 0 00000000 0 00000000 0

// File: dcache_top.f
+incdir+include
verilog/dcache_pkg.sv
verilog/dcache_tag_lookup.sv
verilog/dcache_line_store.sv
verilog/dcache_miss_seq.sv
verilog/dcache_top.sv
bench/dcache_tb.sv

// File: Makefile
# Verilator build and run of the data cache testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --top-module dcache_tb -f dcache_top.f -o dcache_sim
	@out=$$(./obj_dir/dcache_sim); echo "$$out"; echo "$$out" | grep -q "^all tests passed$$"

clean:
	rm -rf obj_dir
